// ==== cic_decim.f ====
+incdir+source
source/cic_pkg.sv
source/cic_integrator.sv
source/cic_rate_ctrl.sv
source/cic_comb.sv
source/cic_gain_norm.sv
source/cic_decim.sv
tb/cic_decim_assert.sv
tb/cic_decim_tb.sv

// ==== Makefile ====
# Verilator build and run of the CIC decimator testbench

SIM  := obj_dir/Vcic_decim_tb
SRCS := $(wildcard source/*.sv source/*.svh tb/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source file or the file list changes
$(SIM): $(SRCS) cic_decim.f
	verilator --binary --timing --assert -Wno-fatal -j 0 \
	  --top-module cic_decim_tb -f cic_decim.f

# Fails unless the pass message shows up in the simulator output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

// ==== tb/cic_decim_tb.sv ====
`timescale 1ns/1ps
`include "cic_decim_config.svh"

module cic_decim_tb;

  import cic_pkg::*;

  localparam int NS      = `CIC_NUM_STAGES;
  localparam int LATENCY = 8;

  // All tests together take about 2300 cycles with average gaps
  localparam int TEST_CYCLES = 2300;
  localparam int MAX_CYCLES  = 2 * TEST_CYCLES + 500;

  logic    clk;
  logic    rst_n;
  logic    in_valid;
  sample_t in_data;
  rate_t   rate_log2;
  logic    out_valid;
  sample_t out_data;

  // Expected outputs with their due cycle, and what the DUT delivered
  sample_t exp_data_q [$];
  int      exp_cyc_q  [$];
  sample_t got_data_q [$];
  int      got_cyc_q  [$];

  // Reference model state, three integrators and three comb delays
  acc_t  m_int [NS];
  acc_t  m_dly [NS];
  int    m_cnt;
  rate_t m_rate;

  int cyc = 0;
  int errors;
  int tests_done;
  int seed = 32'hbd92;

  cic_decim UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .rate_log2 (rate_log2),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // Outputs only change on the rising edge, so the falling edge sees them settled
  always @(negedge clk) begin
    if (out_valid === 1'b1) begin
      got_data_q.push_back(out_data);
      got_cyc_q.push_back(cyc);
    end
  end

  initial begin : watchdog
    while (cyc < MAX_CYCLES) begin
      @(posedge clk);
    end
    $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

  // **************************************************
  // Compare tasks
  // **************************************************

  task automatic compare_sample(input string name, input sample_t expected,
                                input sample_t actual);
    if (actual !== expected) begin
      errors++;
      $display("Mismatch at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
    end
  endtask

  task automatic compare_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
      errors++;
      $display("Mismatch at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
    end
  endtask

  task automatic compare_cycle(input string name, input int expected, input int actual);
    if (actual != expected) begin
      errors++;
      $display("Mismatch at %0t: %s expected cycle %0d, got cycle %0d",
               $time, name, expected, actual);
    end
  endtask

  // **************************************************
  // Reference model and drivers
  // **************************************************

  // One input sample through the integrators, and through the comb
  // and the gain shift whenever it closes a group of R samples
  task automatic model_push(input sample_t x);
    acc_t v;
    acc_t d;
    acc_t scaled;
    v = acc_t'(x);
    m_int[0] = m_int[0] + v;
    for (int k = 1; k < NS; k++) begin
      m_int[k] = m_int[k] + m_int[k-1];
    end
    m_cnt++;
    if (m_cnt == (1 << m_rate)) begin
      v = m_int[NS-1];
      for (int k = 0; k < NS; k++) begin
        d = v - m_dly[k];
        m_dly[k] = v;
        v = d;
      end
      // Gain is R cubed, so divide by 2^(3n) with floor rounding
      scaled = v >>> (3 * m_rate);
      exp_data_q.push_back(sample_t'(scaled));
      // Sampled on the next rising edge, seen here 8 cycles after that
      exp_cyc_q.push_back(cyc + LATENCY);
      m_cnt = 0;
      // The next group runs at the rate present at this boundary
      m_rate = rate_log2;
    end
  endtask

  task automatic drive_sample(input sample_t x);
    @(negedge clk);
    in_valid = 1'b1;
    in_data  = x;
    model_push(x);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      in_valid = 1'b0;
    end
  endtask

  task automatic apply_reset(input rate_t r);
    @(negedge clk);
    in_valid  = 1'b0;
    in_data   = '0;
    rate_log2 = r;
    rst_n     = 1'b0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    for (int k = 0; k < NS; k++) begin
      m_int[k] = '0;
      m_dly[k] = '0;
    end
    m_cnt  = 0;
    m_rate = r;
    exp_data_q.delete();
    exp_cyc_q.delete();
    got_data_q.delete();
    got_cyc_q.delete();
  endtask

  // Waits for the outstanding strobes, then checks count, values and timing
  task automatic check_outputs(input string tag);
    int n;
    idle_cycles(1);
    n = 0;
    while (got_data_q.size() < exp_data_q.size() && n < 4 * LATENCY) begin
      @(negedge clk);
      n++;
    end
    if (got_data_q.size() < exp_data_q.size()) begin
      errors++;
      $display("%s: expected %0d output strobes but only %0d arrived",
               tag, exp_data_q.size(), got_data_q.size());
    end
    // Extra idle time lets any surplus strobe show up
    idle_cycles(2 * LATENCY);
    compare_count({tag, " output count"}, exp_data_q.size(), got_data_q.size());
    for (int i = 0; i < exp_data_q.size() && i < got_data_q.size(); i++) begin
      compare_sample($sformatf("%s out_data[%0d]", tag, i), exp_data_q[i], got_data_q[i]);
      compare_cycle($sformatf("%s out_valid[%0d]", tag, i), exp_cyc_q[i], got_cyc_q[i]);
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests_done++;
    if (errors == err_before) begin
      $display("Test %s finished without errors", name);
    end else begin
      $display("Test %s finished with %0d errors", name, errors - err_before);
    end
  endtask

  // **************************************************
  // Directed tests
  // **************************************************

  task automatic test_dc_gain();
    int      err0;
    sample_t level;
    sample_t levels [3];
    err0 = errors;
    // Largest positive, most negative and an ordinary negative level
    levels[0] = 12'h7ff;
    levels[1] = 12'h800;
    levels[2] = -12'sd300;
    for (int e = 0; e <= `CIC_MAX_RATE_LOG2; e++) begin
      for (int v = 0; v < 3; v++) begin
        level = levels[v];
        apply_reset(rate_t'(e));
        repeat (6 << e) drive_sample(level);
        check_outputs($sformatf("dc r%0d", e));
        // The step response has settled after three outputs
        for (int i = 3; i < got_data_q.size(); i++) begin
          compare_sample($sformatf("dc r%0d out_data[%0d]", e, i), level, got_data_q[i]);
        end
      end
    end
    report_test("dc_gain", err0);
  endtask

  task automatic test_count_latency();
    int err0;
    err0 = errors;
    for (int e = 0; e <= `CIC_MAX_RATE_LOG2; e++) begin
      apply_reset(rate_t'(e));
      idle_cycles(10);
      compare_count($sformatf("latency r%0d outputs while idle", e), 0, got_data_q.size());
      for (int i = 0; i < (5 << e); i++) begin
        drive_sample(sample_t'($random(seed)));
      end
      check_outputs($sformatf("latency r%0d", e));
      compare_count($sformatf("latency r%0d groups", e), 5, got_data_q.size());
    end
    report_test("count_latency", err0);
  endtask

  task automatic test_impulse_step();
    int      err0;
    sample_t amp [4];
    int      pos [4];
    err0 = errors;
    // Runs 0 and 1 are impulses, runs 2 and 3 are steps
    amp[0] = 12'h7ff;
    amp[1] = -12'sd100;
    amp[2] = -12'sd37;
    amp[3] = 12'sd900;
    pos[0] = 5;
    pos[1] = 2;
    pos[2] = 3;
    pos[3] = 6;
    for (int r = 0; r < 4; r++) begin
      apply_reset(3'd2);
      for (int i = 0; i < 64; i++) begin
        if (i == pos[r] || (r >= 2 && i > pos[r])) begin
          drive_sample(amp[r]);
        end else begin
          drive_sample(12'sd0);
        end
      end
      check_outputs($sformatf("impulse_step run %0d", r));
    end
    report_test("impulse_step", err0);
  endtask

  task automatic test_random_gaps();
    int err0;
    int gap;
    err0 = errors;
    apply_reset(3'd3);
    for (int i = 0; i < 160; i++) begin
      drive_sample(sample_t'($random(seed)));
      gap = $random(seed) & 3;
      if (gap > 0) begin
        idle_cycles(gap);
      end
    end
    check_outputs("random_gaps");
    report_test("random_gaps", err0);
  endtask

  task automatic test_rate_change();
    int err0;
    err0 = errors;
    apply_reset(3'd1);
    // Two groups of 2 and the first sample of a third
    for (int i = 0; i < 5; i++) begin
      drive_sample(sample_t'($random(seed)));
    end
    // The last boundary is well through the rate controller by now
    idle_cycles(6);
    rate_log2 = 3'd3;
    // One sample closes the R = 2 group, then four groups of 8
    for (int i = 0; i < 33; i++) begin
      drive_sample(sample_t'($random(seed)));
    end
    for (int i = 0; i < 3; i++) begin
      drive_sample(sample_t'($random(seed)));
    end
    idle_cycles(6);
    rate_log2 = 3'd0;
    // Five more close the R = 8 group, then six groups of 1
    for (int i = 0; i < 11; i++) begin
      drive_sample(sample_t'($random(seed)));
    end
    check_outputs("rate_change");
    compare_count("rate_change groups", 14, got_data_q.size());
    report_test("rate_change", err0);
  endtask

  // **************************************************
  // Main sequence
  // **************************************************

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_data    = '0;
    rate_log2  = '0;
    errors     = 0;
    tests_done = 0;
    test_dc_gain();
    test_count_latency();
    test_impulse_step();
    test_random_gaps();
    test_rate_change();
    $display("Tests run: %0d, errors: %0d, cycles: %0d", tests_done, errors, cyc);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== tb/cic_decim_assert.sv ====
`timescale 1ns/1ps

module cic_decim_assert (
  input logic           clk,
  input logic           rst_n,
  input logic           in_valid,
  input logic           out_valid,
  input logic           dec_valid,
  input cic_pkg::rate_t dec_shift_log2
);

  // Cycles from an accepted input strobe to its output strobe
  localparam int LATENCY = 8;

  // **************************************************
  // Output strobe checks
  // **************************************************

  // Quiet during reset and in the first cycle after release
  a_quiet_reset: assert property (@(posedge clk) (!rst_n || !$past(rst_n)) |-> !out_valid)
    else $error("out_valid asserted during reset or right after it");

  // Every output closes a group whose last input came 8 cycles earlier
  a_out_latency: assert property (@(posedge clk) disable iff (!rst_n)
                                  out_valid |-> $past(in_valid, LATENCY))
    else $error("out_valid without an in_valid %0d cycles earlier", LATENCY);

  // Back to back decimation strobes are only possible at R = 1
  // The second strobe carries the exponent of the group it closed
  a_dec_spacing: assert property (@(posedge clk) disable iff (!rst_n)
                                  (dec_valid && $past(dec_valid)) |-> dec_shift_log2 == '0)
    else $error("dec_valid on consecutive cycles with a nonzero rate exponent");

endmodule

bind cic_decim cic_decim_assert u_assert (
  .clk            (clk),
  .rst_n          (rst_n),
  .in_valid       (in_valid),
  .out_valid      (out_valid),
  .dec_valid      (dec_valid),
  .dec_shift_log2 (dec_shift_log2)
);

// ==== source/cic_decim.sv ====
`timescale 1ns/1ps

module cic_decim (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             in_valid,
  input  cic_pkg::sample_t in_data,
  input  cic_pkg::rate_t   rate_log2,
  output logic             out_valid,
  output cic_pkg::sample_t out_data
);

  import cic_pkg::*;

  // Integrator output, one word per input sample
  logic  int_valid;
  acc_t  int_data;

  // Decimated words and the exponent they were collected with
  logic  dec_valid;
  acc_t  dec_data;
  rate_t dec_shift_log2;

  // Comb output before gain removal
  logic  comb_valid;
  acc_t  comb_data;
  rate_t comb_shift_log2;

  // **************************************************
  // Stage chain, 3 + 1 + 3 + 1 = 8 cycles end to end
  // **************************************************

  cic_integrator u_integrator (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .int_valid (int_valid),
    .int_data  (int_data)
  );

  cic_rate_ctrl u_rate_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .rate_log2      (rate_log2),
    .int_valid      (int_valid),
    .int_data       (int_data),
    .dec_valid      (dec_valid),
    .dec_data       (dec_data),
    .dec_shift_log2 (dec_shift_log2)
  );

  cic_comb u_comb (
    .clk             (clk),
    .rst_n           (rst_n),
    .dec_valid       (dec_valid),
    .dec_data        (dec_data),
    .dec_shift_log2  (dec_shift_log2),
    .comb_valid      (comb_valid),
    .comb_data       (comb_data),
    .comb_shift_log2 (comb_shift_log2)
  );

  cic_gain_norm u_gain_norm (
    .clk             (clk),
    .rst_n           (rst_n),
    .comb_valid      (comb_valid),
    .comb_data       (comb_data),
    .comb_shift_log2 (comb_shift_log2),
    .out_valid       (out_valid),
    .out_data        (out_data)
  );

endmodule

// ==== source/cic_gain_norm.sv ====
`timescale 1ns/1ps
`include "cic_decim_config.svh"

module cic_gain_norm (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             comb_valid,
  input  cic_pkg::acc_t    comb_data,
  input  cic_pkg::rate_t   comb_shift_log2,
  output logic             out_valid,
  output cic_pkg::sample_t out_data
);

  import cic_pkg::*;

  // Shift amount is 3 * exponent, up to 12 for R = 16
  // Five bits hold it for any value of the 3-bit exponent
  logic [4:0] shift_amt;

  // Comb word with the R^3 gain removed
  acc_t scaled;

  // Times three as (2 * n) + n
  assign shift_amt = {comb_shift_log2, 1'b0} + comb_shift_log2;

  // Arithmetic shift rounds toward minus infinity on negative words
  assign scaled = comb_data >>> shift_amt;

  // **************************************************
  // Output register
  // **************************************************

  // The scaled word fits the sample width again, only the low bits are kept
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      out_data  <= '0;
    end else begin
      out_valid <= comb_valid;
      if (comb_valid) begin
        out_data <= scaled[`CIC_IN_WIDTH-1:0];
      end
    end
  end

endmodule

// ==== source/cic_comb.sv ====
`timescale 1ns/1ps
`include "cic_decim_config.svh"

module cic_comb (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           dec_valid,
  input  cic_pkg::acc_t  dec_data,
  input  cic_pkg::rate_t dec_shift_log2,
  output logic           comb_valid,
  output cic_pkg::acc_t  comb_data,
  output cic_pkg::rate_t comb_shift_log2
);

  import cic_pkg::*;

  localparam int NS = `CIC_NUM_STAGES;

  // Held previous input of each differentiator (differential delay of 1)
  acc_t dly_q [NS];

  // Registered difference, valid bit and exponent of each stage
  acc_t          dif_q [NS];
  logic [NS-1:0] vld_q;
  rate_t         shf_q [NS];

  // What each stage sees on its input side
  acc_t          stg_data [NS];
  logic [NS-1:0] stg_vld;
  rate_t         stg_shf  [NS];

  // Stage 0 is fed by the rate controller, the others by the stage before
  always_comb begin
    stg_data[0] = dec_data;
    stg_vld[0]  = dec_valid;
    stg_shf[0]  = dec_shift_log2;
    for (int k = 1; k < NS; k++) begin
      stg_data[k] = dif_q[k-1];
      stg_vld[k]  = vld_q[k-1];
      stg_shf[k]  = shf_q[k-1];
    end
  end

  // **************************************************
  // Differentiator chain
  // **************************************************

  // A stage only moves when its own strobe arrives
  // The strobe walks one stage per cycle, so a new decimated sample
  // may enter stage 0 while an older one is still further down
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= '0;
      for (int k = 0; k < NS; k++) begin
        dly_q[k] <= '0;
        dif_q[k] <= '0;
        shf_q[k] <= '0;
      end
    end else begin
      vld_q <= stg_vld;
      for (int k = 0; k < NS; k++) begin
        if (stg_vld[k]) begin
          // Wrapping subtraction cancels any wrap from the integrators
          dif_q[k] <= stg_data[k] - dly_q[k];
          dly_q[k] <= stg_data[k];
          // The exponent is not used here, it just rides along
          shf_q[k] <= stg_shf[k];
        end
      end
    end
  end

  assign comb_valid      = vld_q[NS-1];
  assign comb_data       = dif_q[NS-1];
  assign comb_shift_log2 = shf_q[NS-1];

endmodule

// ==== source/cic_rate_ctrl.sv ====
`timescale 1ns/1ps
`include "cic_decim_config.svh"

module cic_rate_ctrl (
  input  logic           clk,
  input  logic           rst_n,
  input  cic_pkg::rate_t rate_log2,
  input  logic           int_valid,
  input  cic_pkg::acc_t  int_data,
  output logic           dec_valid,
  output cic_pkg::acc_t  dec_data,
  output cic_pkg::rate_t dec_shift_log2
);

  import cic_pkg::*;

  localparam int CW = `CIC_MAX_RATE_LOG2;

  // Samples still to skip before the next boundary
  logic [CW-1:0] cnt_q;

  // R - 1 for the rate exponent presented on the input
  logic [CW-1:0] cnt_load;

  // Exponent in force for the group being counted
  rate_t rate_q;

  // Low until the first clock after reset release
  logic armed_q;

  // A run of ones shifted left by the exponent and inverted gives 2^n - 1
  assign cnt_load = ~({CW{1'b1}} << rate_log2);

  // **************************************************
  // Group counter and decimation strobe
  // **************************************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      armed_q        <= 1'b0;
      cnt_q          <= '0;
      rate_q         <= '0;
      dec_valid      <= 1'b0;
      dec_data       <= '0;
      dec_shift_log2 <= '0;
    end else begin
      dec_valid <= 1'b0;
      if (!armed_q) begin
        // First group after reset takes the rate seen at reset release
        // The integrator pipeline is still empty, so no sample is lost here
        armed_q <= 1'b1;
        rate_q  <= rate_log2;
        cnt_q   <= cnt_load;
      end else if (int_valid) begin
        if (cnt_q == '0) begin
          // Boundary: hand the R-th word to the comb with its own exponent
          dec_valid      <= 1'b1;
          dec_data       <= int_data;
          dec_shift_log2 <= rate_q;
          // A pending rate change takes effect for the next group only
          rate_q         <= rate_log2;
          cnt_q          <= cnt_load;
        end else begin
          cnt_q <= cnt_q - 1'b1;
        end
      end
    end
  end

endmodule

// ==== source/cic_integrator.sv ====
`timescale 1ns/1ps
`include "cic_decim_config.svh"

module cic_integrator (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             in_valid,
  input  cic_pkg::sample_t in_data,
  output logic             int_valid,
  output cic_pkg::acc_t    int_data
);

  import cic_pkg::*;

  localparam int NS = `CIC_NUM_STAGES;

  // One accumulator per stage, stage 0 sees the raw input
  acc_t acc_q [NS];

  // Valid bit of each stage output, shifted along with the data
  logic [NS-1:0] vld_q;

  // Input sample widened to the accumulator width
  acc_t in_ext;

  // Sign extension keeps negative inputs negative in the wide word
  assign in_ext = {{(`CIC_ACC_WIDTH - `CIC_IN_WIDTH){in_data[`CIC_IN_WIDTH-1]}}, in_data};

  // **************************************************
  // Integrator chain
  // **************************************************

  // Each stage adds the freshly updated value of the stage before it
  // Because a stage only moves on its own valid, every accumulator
  // advances exactly once per input sample, even for back-to-back input
  // Overflow wraps on purpose, the comb section undoes it later
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= '0;
      for (int k = 0; k < NS; k++) begin
        acc_q[k] <= '0;
      end
    end else begin
      vld_q <= {vld_q[NS-2:0], in_valid};
      if (in_valid) begin
        acc_q[0] <= acc_q[0] + in_ext;
      end
      for (int k = 1; k < NS; k++) begin
        if (vld_q[k-1]) begin
          acc_q[k] <= acc_q[k] + acc_q[k-1];
        end
      end
    end
  end

  // The last stage feeds the rate controller
  // Three registers give three cycles from in_valid to int_valid
  assign int_valid = vld_q[NS-1];
  assign int_data  = acc_q[NS-1];

endmodule

// ==== source/cic_pkg.sv ====
`include "cic_decim_config.svh"

package cic_pkg;

  // **************************************************
  // Data types shared by the CIC decimator stages
  // **************************************************

  // Input and output samples in two's complement
  typedef logic signed [`CIC_IN_WIDTH-1:0] sample_t;

  // Integrator and comb words
  // They wrap freely, only the final comb result is meaningful
  typedef logic signed [`CIC_ACC_WIDTH-1:0] acc_t;

  // Rate exponent, R = 2 ** value
  // Three bits cover the range 0 to 4 that the filter supports
  typedef logic [2:0] rate_t;

endpackage

// ==== source/cic_decim_config.svh ====
`ifndef CIC_DECIM_CONFIG_SVH
`define CIC_DECIM_CONFIG_SVH

// **************************************************
// CIC decimator build configuration
// **************************************************

// Filter order, i.e. the number of integrators and of comb stages
`define CIC_NUM_STAGES 3

// Width of the input samples and of the decimated output samples
`define CIC_IN_WIDTH 12

// Largest supported log2 of the decimation rate (R = 16)
`define CIC_MAX_RATE_LOG2 4

// Internal word width, grown by log2 of the worst case gain R^N
`define CIC_ACC_WIDTH (`CIC_IN_WIDTH + `CIC_NUM_STAGES * `CIC_MAX_RATE_LOG2)

`endif
